// File: sim.f
source/mem_req_pkg.sv
source/mux_pkg.sv
source/req_buffer.sv
source/req_mux.sv
source/mem_responder.sv
source/mem_mux_top.sv
bench/mem_mux_asserts.sv
bench/tb_mem_mux.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module tb_mem_mux \
    --Mdir obj_dir -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "No errors" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed (exit status ${status})"
    exit 1
fi

// File: bench/tb_mem_mux.sv
// ==========================================================================
// Testbench for the two-client memory mux. Two random clients send reads
// and writes into disjoint address halves, and a reference model predicts
// every response per client. Stretches of rsp_ready low force the whole
// back-pressure chain. A watchdog bounds the run time.
// ==========================================================================

`timescale 1ns/100ps
`default_nettype none

module tb_mem_mux;

    localparam int BUF_DEPTH          = 8;
    localparam int RSP_DEPTH          = 8;
    localparam int RESERVED_MDATA_IDX = 7;
    localparam int ADDR_W             = mem_req_pkg::ADDR_W;
    localparam int DATA_W             = mem_req_pkg::DATA_W;
    localparam int MDATA_W            = mem_req_pkg::MDATA_W;
    localparam int NUM_CLIENTS        = mux_pkg::NUM_CLIENTS;
    localparam int WORDS              = 2 ** ADDR_W;
    localparam int CLK_PERIOD         = 40;
    localparam int RESET_CYCLES       = 4;
    localparam int NUM_REQS           = 2000;
    localparam int WATCHDOG_NS        = NUM_REQS * 40 * CLK_PERIOD;
    localparam logic [31:0] SEED      = 32'h1eda3b3b;

    // One predicted response, queued at request time
    typedef struct packed {
        mem_req_pkg::mem_op_e  op;
        logic [DATA_W-1:0]     data;
        logic [MDATA_W-1:0]    mdata;
    } exp_rsp_t;

    logic                                             clk;
    logic                                             reset_n;
    logic [NUM_CLIENTS-1:0]                           req_valid;
    mem_req_pkg::mem_op_e [NUM_CLIENTS-1:0]           req_op;
    logic [NUM_CLIENTS-1:0][ADDR_W-1:0]               req_addr;
    logic [NUM_CLIENTS-1:0][DATA_W-1:0]               req_data;
    logic [NUM_CLIENTS-1:0][MDATA_W-1:0]              req_mdata;
    logic [NUM_CLIENTS-1:0]                           req_almost_full;
    logic                                             rsp_ready;
    logic [NUM_CLIENTS-1:0]                           rsp_valid;
    mem_req_pkg::mem_op_e                             rsp_op;
    logic [DATA_W-1:0]                                rsp_data;
    logic [MDATA_W-1:0]                               rsp_mdata;

    // Reference model state
    logic [DATA_W-1:0]      model_mem [WORDS];
    exp_rsp_t               exp_q0 [$];
    exp_rsp_t               exp_q1 [$];
    int                     sent;
    int                     cycle;
    logic [NUM_CLIENTS-1:0] saw_almost_full;

    mem_mux_top #(
        .BUF_DEPTH(BUF_DEPTH),
        .RSP_DEPTH(RSP_DEPTH),
        .RESERVED_MDATA_IDX(RESERVED_MDATA_IDX)
    ) dut0 (
        .clk, .reset_n,
        .req_valid, .req_op, .req_addr, .req_data, .req_mdata, .req_almost_full,
        .rsp_ready, .rsp_valid, .rsp_op, .rsp_data, .rsp_mdata
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ======================================================================
    // Failure reporting and compare tasks
    // ======================================================================

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_op(input string sig, input mem_req_pkg::mem_op_e exp,
                              input mem_req_pkg::mem_op_e act);
        if (exp !== act)
            stop_with_failure($sformatf("Mismatch at %0t ns: %s expected %s, actual %s",
                                        $time, sig, exp.name(), act.name()));
    endtask

    task automatic compare_data(input string sig, input logic [DATA_W-1:0] exp,
                                input logic [DATA_W-1:0] act);
        if (exp !== act)
            stop_with_failure($sformatf("Mismatch at %0t ns: %s expected %h, actual %h",
                                        $time, sig, exp, act));
    endtask

    task automatic compare_mdata(input string sig, input logic [MDATA_W-1:0] exp,
                                 input logic [MDATA_W-1:0] act);
        if (exp !== act)
            stop_with_failure($sformatf("Mismatch at %0t ns: %s expected %h, actual %h",
                                        $time, sig, exp, act));
    endtask

    task automatic compare_flags(input string sig, input logic [NUM_CLIENTS-1:0] exp,
                                 input logic [NUM_CLIENTS-1:0] act);
        if (exp !== act)
            stop_with_failure($sformatf("Mismatch at %0t ns: %s expected %b, actual %b",
                                        $time, sig, exp, act));
    endtask

    // ======================================================================
    // Client stimulus and response checking
    // ======================================================================

    // Decide one cycle of traffic for client p and record the expected answer.
    // Client p owns the address half whose top bit equals p
    task automatic drive_client(input int p);
        logic [31:0]          r;
        mem_req_pkg::mem_op_e op;
        logic [ADDR_W-1:0]    addr;
        logic [DATA_W-1:0]    data;
        logic [MDATA_W-1:0]   md;
        exp_rsp_t             exp;
        r = $urandom();
        if (req_almost_full[p] || sent >= NUM_REQS || r[3:0] < 4'd5)
            req_valid[p] <= 1'b0;
        else
        begin
            op   = mem_req_pkg::mem_op_e'(r[4]);
            addr = ADDR_W'($urandom());
            addr[ADDR_W-1] = p[0];
            data = $urandom();
            md   = MDATA_W'($urandom());
            md[RESERVED_MDATA_IDX] = 1'b0;
            req_valid[p] <= 1'b1;
            req_op[p]    <= op;
            req_addr[p]  <= addr;
            req_data[p]  <= data;
            req_mdata[p] <= md;
            // A write answers 0, a read answers the latest word of this client
            exp.op    = op;
            exp.mdata = md;
            if (op == mem_req_pkg::MEM_WR)
            begin
                exp.data = '0;
                model_mem[addr] = data;
            end
            else
                exp.data = model_mem[addr];
            if (p == 0)
                exp_q0.push_back(exp);
            else
                exp_q1.push_back(exp);
            sent++;
        end
    endtask

    // A response seen with rsp_ready high is consumed at the next edge
    task automatic check_response(input int p);
        exp_rsp_t exp;
        if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0))
            stop_with_failure($sformatf("Client %0d got a response at %0t ns with no request outstanding",
                                        p, $time));
        else
        begin
            if (p == 0)
                exp = exp_q0.pop_front();
            else
                exp = exp_q1.pop_front();
            compare_op($sformatf("rsp_op (client %0d)", p), exp.op, rsp_op);
            compare_data($sformatf("rsp_data (client %0d)", p), exp.data, rsp_data);
            compare_mdata($sformatf("rsp_mdata (client %0d)", p), exp.mdata, rsp_mdata);
        end
    endtask

    // Outputs are sampled on the falling edge, well away from the drive edge
    always @(negedge clk)
    begin
        if (reset_n)
        begin
            saw_almost_full = saw_almost_full | req_almost_full;
            if (rsp_valid == 2'b11)
                stop_with_failure("A response was valid for both clients at once");
            else if (rsp_ready)
            begin
                for (int p = 0; p < NUM_CLIENTS; p++)
                    if (rsp_valid[p])
                        check_response(p);
            end
        end
    end

    // Bound from the number of requests with generous cycles per request
    initial
    begin
        #(WATCHDOG_NS);
        stop_with_failure("Watchdog expired before all responses came back");
    end

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial
    begin
        clk             = 1'b0;
        reset_n         = 1'b0;
        req_valid       = '0;
        req_op          = '{default: mem_req_pkg::MEM_RD};
        req_addr        = '0;
        req_data        = '0;
        req_mdata       = '0;
        rsp_ready       = 1'b0;
        sent            = 0;
        cycle           = 0;
        saw_almost_full = '0;
        for (int i = 0; i < WORDS; i++)
            model_mem[i] = '0;
        void'($urandom(SEED));

        // Reset is seen at the first four edges, outputs must stay low
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1)
                reset_n <= 1'b1;
            @(negedge clk);
            compare_flags("rsp_valid", '0, rsp_valid);
            compare_flags("req_almost_full", '0, req_almost_full);
        end
        repeat (2)
        begin
            @(negedge clk);
            compare_flags("rsp_valid", '0, rsp_valid);
            compare_flags("req_almost_full", '0, req_almost_full);
        end

        // Random traffic, with a long rsp_ready-low stretch every 400 cycles
        while (sent < NUM_REQS)
        begin
            @(posedge clk);
            cycle++;
            if ((cycle % 400) < 120)
                rsp_ready <= 1'b0;
            else
                rsp_ready <= ($urandom_range(99) < 60);
            for (int p = 0; p < NUM_CLIENTS; p++)
                drive_client(p);
        end

        // Drain everything, then allow time for any stray response
        @(posedge clk);
        req_valid <= '0;
        rsp_ready <= 1'b1;
        while (exp_q0.size() != 0 || exp_q1.size() != 0)
            @(posedge clk);
        repeat (10) @(posedge clk);

        if (saw_almost_full != 2'b11)
            stop_with_failure("req_almost_full never rose for one of the clients");
        else
        begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: bench/mem_mux_asserts.sv
// ==========================================================================
// Concurrent checks on the request mux, bound into every req_mux instance.
// They cover the tag bit on incoming heads, flow control toward the
// memory, round-robin fairness and one-hot response routing.
// ==========================================================================

`timescale 1ns/100ps
`default_nettype none

module mem_mux_asserts #(
    parameter int RESERVED_MDATA_IDX = 7
) (
    input  logic                                                   clk,
    input  logic                                                   reset_n,
    input  logic [mux_pkg::NUM_CLIENTS-1:0]                        head_valid,
    input  logic [mux_pkg::NUM_CLIENTS-1:0][mem_req_pkg::MDATA_W-1:0] head_mdata,
    input  logic [mux_pkg::NUM_CLIENTS-1:0]                        deq,
    input  logic                                                   grant,
    input  logic                                                   mem_almost_full,
    input  logic                                                   mem_valid,
    input  logic [mux_pkg::NUM_CLIENTS-1:0]                        rsp_valid
);

    // Clients leave the routing bit clear
    head0_tag_clear: assert property (@(posedge clk) disable iff (!reset_n)
        head_valid[0] |-> !head_mdata[0][RESERVED_MDATA_IDX])
        else $error("Client 0 head carries the reserved mdata bit");

    head1_tag_clear: assert property (@(posedge clk) disable iff (!reset_n)
        head_valid[1] |-> !head_mdata[1][RESERVED_MDATA_IDX])
        else $error("Client 1 head carries the reserved mdata bit");

    // No issue follows a cycle where the memory reported almost full
    issue_flow: assert property (@(posedge clk) disable iff (!reset_n)
        mem_almost_full |=> !mem_valid)
        else $error("Request issued while memory was almost full");

    // Back-to-back contended grants alternate between the clients
    fair_grant: assert property (@(posedge clk) disable iff (!reset_n)
        (grant && (&head_valid) && $past(grant && (&head_valid))) |-> (deq != $past(deq)))
        else $error("Same client won two contended grants in a row");

    rsp_one_hot: assert property (@(posedge clk) disable iff (!reset_n)
        !(&rsp_valid))
        else $error("Response routed to both clients");

endmodule

bind req_mux mem_mux_asserts #(.RESERVED_MDATA_IDX(RESERVED_MDATA_IDX)) asserts0 (
    .clk(clk),
    .reset_n(reset_n),
    .head_valid(head_valid),
    .head_mdata(head_mdata),
    .deq(deq),
    .grant(grant),
    .mem_almost_full(mem_almost_full),
    .mem_valid(mem_valid),
    .rsp_valid(rsp_valid)
);

`default_nettype wire

// File: source/mem_mux_top.sv
// ==========================================================================
// Top level of the two-client memory mux. Each client feeds its own
// request buffer, the mux arbitrates and tags, and the responder answers.
// Depths and the reserved mdata bit are set here and passed down.
// ==========================================================================

`timescale 1ns/100ps
`default_nettype none

module mem_mux_top #(
    parameter int BUF_DEPTH          = 8,
    parameter int RSP_DEPTH          = 8,
    parameter int RESERVED_MDATA_IDX = 7
) (
    input  logic                                                   clk,
    input  logic                                                   reset_n,
    input  logic [mux_pkg::NUM_CLIENTS-1:0]                        req_valid,
    input  mem_req_pkg::mem_op_e [mux_pkg::NUM_CLIENTS-1:0]        req_op,
    input  logic [mux_pkg::NUM_CLIENTS-1:0][mem_req_pkg::ADDR_W-1:0]  req_addr,
    input  logic [mux_pkg::NUM_CLIENTS-1:0][mem_req_pkg::DATA_W-1:0]  req_data,
    input  logic [mux_pkg::NUM_CLIENTS-1:0][mem_req_pkg::MDATA_W-1:0] req_mdata,
    output logic [mux_pkg::NUM_CLIENTS-1:0]                        req_almost_full,
    input  logic                                                   rsp_ready,
    output logic [mux_pkg::NUM_CLIENTS-1:0]                        rsp_valid,
    output mem_req_pkg::mem_op_e                                   rsp_op,
    output logic [mem_req_pkg::DATA_W-1:0]                         rsp_data,
    output logic [mem_req_pkg::MDATA_W-1:0]                        rsp_mdata
);

    // Buffer heads and pops, one slot per client
    logic [mux_pkg::NUM_CLIENTS-1:0]                        head_valid;
    mem_req_pkg::mem_op_e [mux_pkg::NUM_CLIENTS-1:0]        head_op;
    logic [mux_pkg::NUM_CLIENTS-1:0][mem_req_pkg::ADDR_W-1:0]  head_addr;
    logic [mux_pkg::NUM_CLIENTS-1:0][mem_req_pkg::DATA_W-1:0]  head_data;
    logic [mux_pkg::NUM_CLIENTS-1:0][mem_req_pkg::MDATA_W-1:0] head_mdata;
    logic [mux_pkg::NUM_CLIENTS-1:0]                        deq;

    // Tagged request and response between the mux and the memory
    logic                            mem_almost_full;
    logic                            mem_valid;
    mem_req_pkg::mem_op_e            mem_op;
    logic [mem_req_pkg::ADDR_W-1:0]  mem_addr;
    logic [mem_req_pkg::DATA_W-1:0]  mem_data;
    logic [mem_req_pkg::MDATA_W-1:0] mem_mdata;
    logic                            mem_rsp_valid;
    mem_req_pkg::mem_op_e            mem_rsp_op;
    logic [mem_req_pkg::DATA_W-1:0]  mem_rsp_data;
    logic [mem_req_pkg::MDATA_W-1:0] mem_rsp_mdata;

    req_buffer #(.BUF_DEPTH(BUF_DEPTH)) buf0 (
        .clk, .reset_n,
        .wr_valid(req_valid[0]), .wr_op(req_op[0]), .wr_addr(req_addr[0]),
        .wr_data(req_data[0]), .wr_mdata(req_mdata[0]),
        .almost_full(req_almost_full[0]),
        .head_valid(head_valid[0]), .head_op(head_op[0]), .head_addr(head_addr[0]),
        .head_data(head_data[0]), .head_mdata(head_mdata[0]),
        .deq(deq[0])
    );

    req_buffer #(.BUF_DEPTH(BUF_DEPTH)) buf1 (
        .clk, .reset_n,
        .wr_valid(req_valid[1]), .wr_op(req_op[1]), .wr_addr(req_addr[1]),
        .wr_data(req_data[1]), .wr_mdata(req_mdata[1]),
        .almost_full(req_almost_full[1]),
        .head_valid(head_valid[1]), .head_op(head_op[1]), .head_addr(head_addr[1]),
        .head_data(head_data[1]), .head_mdata(head_mdata[1]),
        .deq(deq[1])
    );

    req_mux #(.RESERVED_MDATA_IDX(RESERVED_MDATA_IDX)) mux0 (
        .clk, .reset_n,
        .head_valid, .head_op, .head_addr, .head_data, .head_mdata, .deq,
        .mem_almost_full, .mem_valid, .mem_op, .mem_addr, .mem_data, .mem_mdata,
        .mem_rsp_valid, .mem_rsp_op, .mem_rsp_data, .mem_rsp_mdata,
        .rsp_valid, .rsp_op, .rsp_data, .rsp_mdata
    );

    mem_responder #(.RSP_DEPTH(RSP_DEPTH)) mem0 (
        .clk, .reset_n,
        .mem_valid, .mem_op, .mem_addr, .mem_data, .mem_mdata, .mem_almost_full,
        .mem_rsp_valid, .mem_rsp_op, .mem_rsp_data, .mem_rsp_mdata,
        .rsp_ready
    );

endmodule

`default_nettype wire

// File: source/mem_responder.sv
// ==========================================================================
// Memory model behind the mux. Each request is registered, the RAM is
// read or written in the next cycle and the answer goes into a response
// queue that drains whenever rsp_ready is high. mem_almost_full holds the
// mux off early enough for everything already in flight to fit.
// ==========================================================================

`timescale 1ns/100ps
`default_nettype none

module mem_responder #(
    parameter int RSP_DEPTH = 8
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               mem_valid,
    input  mem_req_pkg::mem_op_e               mem_op,
    input  logic [mem_req_pkg::ADDR_W-1:0]     mem_addr,
    input  logic [mem_req_pkg::DATA_W-1:0]     mem_data,
    input  logic [mem_req_pkg::MDATA_W-1:0]    mem_mdata,
    output logic                               mem_almost_full,
    output logic                               mem_rsp_valid,
    output mem_req_pkg::mem_op_e               mem_rsp_op,
    output logic [mem_req_pkg::DATA_W-1:0]     mem_rsp_data,
    output logic [mem_req_pkg::MDATA_W-1:0]    mem_rsp_mdata,
    input  logic                               rsp_ready
);

    localparam int WORDS = 2 ** mem_req_pkg::ADDR_W;
    localparam int PTR_W = $clog2(RSP_DEPTH);
    localparam int CNT_W = $clog2(RSP_DEPTH + 1);

    // ======================================================================
    // Request stage and RAM
    // ======================================================================

    logic                            s1_valid;
    mem_req_pkg::mem_op_e            s1_op;
    logic [mem_req_pkg::ADDR_W-1:0]  s1_addr;
    logic [mem_req_pkg::DATA_W-1:0]  s1_data;
    logic [mem_req_pkg::MDATA_W-1:0] s1_mdata;

    logic [mem_req_pkg::DATA_W-1:0]  ram [WORDS];
    logic [mem_req_pkg::DATA_W-1:0]  s1_rsp_data;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= mem_valid;
        s1_op    <= mem_op;
        s1_addr  <= mem_addr;
        s1_data  <= mem_data;
        s1_mdata <= mem_mdata;
    end

    // The RAM starts out as all zeros, so unwritten words read back 0
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < WORDS; i++)
                ram[i] <= '0;
        end
        else if (s1_valid && s1_op == mem_req_pkg::MEM_WR)
            ram[s1_addr] <= s1_data;
    end

    // A read answers with the stored word, a write answers with 0
    assign s1_rsp_data = (s1_op == mem_req_pkg::MEM_RD) ? ram[s1_addr] : '0;

    // ======================================================================
    // Response queue
    // ======================================================================

    mem_req_pkg::mem_op_e            q_op    [RSP_DEPTH];
    logic [mem_req_pkg::DATA_W-1:0]  q_data  [RSP_DEPTH];
    logic [mem_req_pkg::MDATA_W-1:0] q_mdata [RSP_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign pop = mem_rsp_valid && rsp_ready;

    // The response keeps the full mdata, routing bit included
    always_ff @(posedge clk)
    begin
        if (s1_valid)
        begin
            q_op[wr_ptr]    <= s1_op;
            q_data[wr_ptr]  <= s1_rsp_data;
            q_mdata[wr_ptr] <= s1_mdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (s1_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({s1_valid, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // Three free entries cover a grant in progress, the issue register
    // and the RAM stage, so a write into a full queue cannot happen
    assign mem_almost_full = (count >= CNT_W'(RSP_DEPTH - 3));

    assign mem_rsp_valid = (count != '0);
    assign mem_rsp_op    = q_op[rd_ptr];
    assign mem_rsp_data  = q_data[rd_ptr];
    assign mem_rsp_mdata = q_mdata[rd_ptr];

endmodule

`default_nettype wire

// File: source/req_mux.sv
// ==========================================================================
// Two-client request mux. Picks one buffered head per cycle by round robin,
// stamps the winner index into the reserved mdata bit and registers the
// request toward the memory. Responses are steered back by that bit,
// which is cleared again before the clients see the tag.
// ==========================================================================

`timescale 1ns/100ps
`default_nettype none

module req_mux #(
    parameter int RESERVED_MDATA_IDX = 7
) (
    input  logic                                                   clk,
    input  logic                                                   reset_n,

    // Buffered heads, one slot per client
    input  logic [mux_pkg::NUM_CLIENTS-1:0]                        head_valid,
    input  mem_req_pkg::mem_op_e [mux_pkg::NUM_CLIENTS-1:0]        head_op,
    input  logic [mux_pkg::NUM_CLIENTS-1:0][mem_req_pkg::ADDR_W-1:0]  head_addr,
    input  logic [mux_pkg::NUM_CLIENTS-1:0][mem_req_pkg::DATA_W-1:0]  head_data,
    input  logic [mux_pkg::NUM_CLIENTS-1:0][mem_req_pkg::MDATA_W-1:0] head_mdata,
    output logic [mux_pkg::NUM_CLIENTS-1:0]                        deq,

    // Request toward the memory responder
    input  logic                                                   mem_almost_full,
    output logic                                                   mem_valid,
    output mem_req_pkg::mem_op_e                                   mem_op,
    output logic [mem_req_pkg::ADDR_W-1:0]                         mem_addr,
    output logic [mem_req_pkg::DATA_W-1:0]                         mem_data,
    output logic [mem_req_pkg::MDATA_W-1:0]                        mem_mdata,

    // Tagged response from the memory responder
    input  logic                                                   mem_rsp_valid,
    input  mem_req_pkg::mem_op_e                                   mem_rsp_op,
    input  logic [mem_req_pkg::DATA_W-1:0]                         mem_rsp_data,
    input  logic [mem_req_pkg::MDATA_W-1:0]                        mem_rsp_mdata,

    // Untagged response, broadcast with a per-client valid
    output logic [mux_pkg::NUM_CLIENTS-1:0]                        rsp_valid,
    output mem_req_pkg::mem_op_e                                   rsp_op,
    output logic [mem_req_pkg::DATA_W-1:0]                         rsp_data,
    output logic [mem_req_pkg::MDATA_W-1:0]                        rsp_mdata
);

    // ======================================================================
    // Arbitration
    // ======================================================================

    // Client that won the most recent grant
    mux_pkg::client_e last_winner;
    mux_pkg::client_e winner;
    logic             grant;

    // A grant happens whenever some head is waiting and the memory has room
    assign grant = (|head_valid) && !mem_almost_full;

    // With two clients round robin reduces to one term.
    // Client 1 wins when alone, or when both ask and client 0 won last
    assign winner = (head_valid[1] && (!head_valid[0] || last_winner == mux_pkg::CLIENT_0))
                    ? mux_pkg::CLIENT_1 : mux_pkg::CLIENT_0;

    // Reset to client 1 so that client 0 takes the first contention
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            last_winner <= mux_pkg::CLIENT_1;
        else if (grant)
            last_winner <= winner;
    end

    // Pop the winning head, its next entry shows after the edge
    assign deq[0] = grant && (winner == mux_pkg::CLIENT_0);
    assign deq[1] = grant && (winner == mux_pkg::CLIENT_1);

    // ======================================================================
    // Issue register
    // ======================================================================

    // Winner's mdata with the routing bit set to its index.
    // Clients must send that bit as 0
    logic [mem_req_pkg::MDATA_W-1:0] win_mdata;

    always_comb
    begin
        win_mdata = head_mdata[winner];
        win_mdata[RESERVED_MDATA_IDX] = winner;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            mem_valid <= 1'b0;
        else
            mem_valid <= grant;
    end

    // Payload only matters when mem_valid is set
    always_ff @(posedge clk)
    begin
        if (grant)
        begin
            mem_op    <= head_op[winner];
            mem_addr  <= head_addr[winner];
            mem_data  <= head_data[winner];
            mem_mdata <= win_mdata;
        end
    end

    // ======================================================================
    // Response routing
    // ======================================================================

    // The tag bit names the client that issued the request
    mux_pkg::client_e rsp_tag;
    assign rsp_tag = mux_pkg::client_e'(mem_rsp_mdata[RESERVED_MDATA_IDX]);

    assign rsp_valid[0] = mem_rsp_valid && (rsp_tag == mux_pkg::CLIENT_0);
    assign rsp_valid[1] = mem_rsp_valid && (rsp_tag == mux_pkg::CLIENT_1);

    // Op and data go to both clients, only the valid is steered
    assign rsp_op   = mem_rsp_op;
    assign rsp_data = mem_rsp_data;

    // Give the reserved bit back as the 0 that the client sent
    always_comb
    begin
        rsp_mdata = mem_rsp_mdata;
        rsp_mdata[RESERVED_MDATA_IDX] = 1'b0;
    end

endmodule

`default_nettype wire

// File: source/req_buffer.sv
// ==========================================================================
// Request FIFO for one client. The client writes while almost_full is low,
// and the mux pops the head with deq when that client wins arbitration.
// The head is shown combinationally from storage; there is no bypass.
// ==========================================================================

`timescale 1ns/100ps
`default_nettype none

module req_buffer #(
    parameter int BUF_DEPTH = 8
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               wr_valid,
    input  mem_req_pkg::mem_op_e               wr_op,
    input  logic [mem_req_pkg::ADDR_W-1:0]     wr_addr,
    input  logic [mem_req_pkg::DATA_W-1:0]     wr_data,
    input  logic [mem_req_pkg::MDATA_W-1:0]    wr_mdata,
    output logic                               almost_full,
    output logic                               head_valid,
    output mem_req_pkg::mem_op_e               head_op,
    output logic [mem_req_pkg::ADDR_W-1:0]     head_addr,
    output logic [mem_req_pkg::DATA_W-1:0]     head_data,
    output logic [mem_req_pkg::MDATA_W-1:0]    head_mdata,
    input  logic                               deq
);

    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    // Entry storage, one array per request field
    mem_req_pkg::mem_op_e            op_q    [BUF_DEPTH];
    logic [mem_req_pkg::ADDR_W-1:0]  addr_q  [BUF_DEPTH];
    logic [mem_req_pkg::DATA_W-1:0]  data_q  [BUF_DEPTH];
    logic [mem_req_pkg::MDATA_W-1:0] mdata_q [BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Pointers wrap at BUF_DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    always_ff @(posedge clk)
    begin
        if (wr_valid)
        begin
            op_q[wr_ptr]    <= wr_op;
            addr_q[wr_ptr]  <= wr_addr;
            data_q[wr_ptr]  <= wr_data;
            mdata_q[wr_ptr] <= wr_mdata;
        end
    end

    // The mux only pops a valid head, so deq never sees an empty FIFO
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (deq)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({wr_valid, deq})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // Two free entries of slack cover the client's one cycle of latency
    assign almost_full = (count >= CNT_W'(BUF_DEPTH - 2));

    assign head_valid = (count != '0);
    assign head_op    = op_q[rd_ptr];
    assign head_addr  = addr_q[rd_ptr];
    assign head_data  = data_q[rd_ptr];
    assign head_mdata = mdata_q[rd_ptr];

endmodule

`default_nettype wire

// File: source/mux_pkg.sv
// ==========================================================================
// Client numbering for the arbitration side of the request mux.
// The client index is also the value stamped into the reserved mdata bit.
// ==========================================================================

`default_nettype none

package mux_pkg;

    // Two clients are fixed by the design.
    // The arbiter and the one-bit tag both depend on it
    localparam int NUM_CLIENTS = 2;

    // Client index, used for the last winner and the routing tag
    typedef enum logic {
        CLIENT_0 = 1'b0,
        CLIENT_1 = 1'b1
    } client_e;

endpackage

`default_nettype wire

// File: source/mem_req_pkg.sv
// ==========================================================================
// Field widths and opcodes shared by the request path and the memory
// responder. Modules refer to these by scoped name only.
// ==========================================================================

`default_nettype none

package mem_req_pkg;

    // ======================================================================
    // Request and response fields
    // ======================================================================

    // Word address into the responder RAM
    localparam int ADDR_W = 6;

    // Write data and read response data
    localparam int DATA_W = 32;

    // Opaque client tag, returned unchanged with the response.
    // One bit of it is borrowed by the mux for routing
    localparam int MDATA_W = 8;

    // ======================================================================
    // Opcodes
    // ======================================================================

    // Reads and writes share one request channel
    typedef enum logic {
        MEM_RD = 1'b0,
        MEM_WR = 1'b1
    } mem_op_e;

endpackage

`default_nettype wire
